/* design/zx_bus_pkg.sv */
package zx_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Z80 bus widths
	////////////////////////////////////////////////////////////////////////////

	// cpu address
	typedef logic [15:0] z_addr_t;

	// cpu data byte
	typedef logic [7:0] z_data_t;

	////////////////////////////////////////////////////////////////////////////
	// I/O ports and strobe sampling
	////////////////////////////////////////////////////////////////////////////

	// low byte of the pager port
	// window number sits in address bits 15 and 14
	localparam logic [7:0] PAGER_PORT_LO = 8'hf7;

	// flops per strobe before edge detection
	localparam int SYNC_STAGES = 2;

endpackage

/* design/zx_mem_pkg.sv */
package zx_mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// paged memory side
	////////////////////////////////////////////////////////////////////////////

	// 2M byte space, page number above window offset
	typedef logic [20:0] mem_addr_t;

	// bit 7 set for ram, bits 6..0 page number
	typedef logic [7:0] page_t;

	// window index, from cpu address bits 15..14
	typedef logic [1:0] window_t;

	// offset inside a 16k window
	typedef logic [13:0] offset_t;

	// rom 0, ram 5, ram 2, ram 0
	localparam page_t RESET_PAGES [4] = '{8'h00, 8'h85, 8'h82, 8'h80};

	////////////////////////////////////////////////////////////////////////////
	// access sequencer
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_release,
		st_hold
	} mem_state_t;

endpackage

/* design/z80_cycle_if.sv */
interface z80_cycle_if;
	import zx_bus_pkg::*;

	// single cycle start pulses in the fclk domain
	logic    mem_rd_start;
	logic    mem_wr_start;
	logic    io_wr_start;

	// active strobe went back high
	logic    cyc_end;

	// sampled together with the strobes
	z_addr_t addr;
	z_data_t wdata;

	modport src (
		output mem_rd_start, mem_wr_start, io_wr_start, cyc_end, addr, wdata
	);

	modport pager (
		input io_wr_start, addr, wdata
	);

	modport seq (
		input mem_rd_start, mem_wr_start, cyc_end, addr, wdata
	);

endinterface

/* design/z80_bus_sync.sv */
module z80_bus_sync (
	input  logic                fclk,
	input  logic                rst_n,
	input  zx_bus_pkg::z_addr_t za,
	input  zx_bus_pkg::z_data_t zd_in,
	input  logic                mreq_n,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic                wr_n,
	z80_cycle_if.src            cyc
);
	import zx_bus_pkg::*;

	// strobe order mreq, iorq, rd, wr
	logic [3:0] stb_sync [SYNC_STAGES];
	z_addr_t    addr_sync [SYNC_STAGES];
	z_data_t    data_sync [SYNC_STAGES];
	logic [3:0] stb;
	logic       mem_rd_act;
	logic       mem_wr_act;
	logic       io_wr_act;
	logic [2:0] act_q;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < SYNC_STAGES; i++)
				stb_sync[i] <= '1;
		end
		else
		begin
			stb_sync[0] <= {mreq_n, iorq_n, rd_n, wr_n};
			for (int i = 1; i < SYNC_STAGES; i++)
				stb_sync[i] <= stb_sync[i-1];
		end
	end

	// same depth as the strobes, so addr and data line up with the pulses
	always_ff @(posedge fclk)
	begin
		addr_sync[0] <= za;
		data_sync[0] <= zd_in;
		for (int i = 1; i < SYNC_STAGES; i++)
		begin
			addr_sync[i] <= addr_sync[i-1];
			data_sync[i] <= data_sync[i-1];
		end
		cyc.addr  <= addr_sync[SYNC_STAGES-1];
		cyc.wdata <= data_sync[SYNC_STAGES-1];
	end

	assign stb        = stb_sync[SYNC_STAGES-1];
	assign mem_rd_act = !stb[3] && !stb[1];
	assign mem_wr_act = !stb[3] && !stb[0];
	assign io_wr_act  = !stb[2] && !stb[0];

	// edge register
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			act_q            <= '0;
			cyc.mem_rd_start <= 1'b0;
			cyc.mem_wr_start <= 1'b0;
			cyc.io_wr_start  <= 1'b0;
			cyc.cyc_end      <= 1'b0;
		end
		else
		begin
			act_q            <= {mem_rd_act, mem_wr_act, io_wr_act};
			cyc.mem_rd_start <= mem_rd_act && !act_q[2];
			cyc.mem_wr_start <= mem_wr_act && !act_q[1];
			cyc.io_wr_start  <= io_wr_act && !act_q[0];
			cyc.cyc_end      <= (|act_q) && !(mem_rd_act || mem_wr_act || io_wr_act);
		end
	end

	// the cpu runs one kind of cycle at a time
	a_one_start: assert property (@(posedge fclk) disable iff (!rst_n)
		$onehot0({cyc.mem_rd_start, cyc.mem_wr_start, cyc.io_wr_start}));

endmodule

/* design/window_pager.sv */
module window_pager (
	input  logic                  fclk,
	input  logic                  rst_n,
	z80_cycle_if.pager            cyc,
	output zx_mem_pkg::mem_addr_t mem_addr,
	output logic                  rom
);
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	page_t   pages [4];
	window_t wr_win;
	window_t rd_win;
	offset_t offset;
	page_t   cur_page;
	logic    port_hit;

	////////////////////////////////////////////////////////////////////////////
	// page registers
	////////////////////////////////////////////////////////////////////////////

	assign port_hit = cyc.addr[7:0] == PAGER_PORT_LO;

	// high address byte of the OUT picks the window
	assign wr_win = cyc.addr[15:14];

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			pages <= RESET_PAGES;
		end
		else if (cyc.io_wr_start && port_hit)
		begin
			pages[wr_win] <= cyc.wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// address translation
	////////////////////////////////////////////////////////////////////////////

	assign rd_win   = cyc.addr[15:14];
	assign offset   = cyc.addr[13:0];
	assign cur_page = pages[rd_win];

	// page number on top of the window offset
	assign mem_addr = {cur_page[6:0], offset};

	// bit 7 clear selects rom
	assign rom = !cur_page[7];

endmodule

/* design/mem_cycle.sv */
module mem_cycle (
	input  logic                  fclk,
	input  logic                  rst_n,
	z80_cycle_if.seq              cyc,
	input  zx_mem_pkg::mem_addr_t map_addr,
	input  logic                  map_rom,
	output logic                  mem_req,
	input  logic                  mem_ack,
	output zx_mem_pkg::mem_addr_t mem_addr,
	output logic                  mem_rnw,
	output zx_bus_pkg::z_data_t   mem_wdata,
	input  zx_bus_pkg::z_data_t   mem_rdata,
	output logic                  mem_rom,
	output logic                  wait_n,
	output zx_bus_pkg::z_data_t   zd_out,
	output logic                  zd_oe
);
	import zx_mem_pkg::*;

	mem_state_t state;
	logic       go;

	// rom writes are dropped here
	assign go = (state == st_idle) &&
		(cyc.mem_rd_start || (cyc.mem_wr_start && !map_rom));

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			state   <= st_idle;
			mem_req <= 1'b0;
			mem_rnw <= 1'b1;
			wait_n  <= 1'b1;
			zd_oe   <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (go)
					begin
						state   <= st_request;
						mem_req <= 1'b1;
						mem_rnw <= cyc.mem_rd_start;
						wait_n  <= 1'b0;
					end
				end
				st_request:
				begin
					if (mem_ack)
					begin
						state   <= st_release;
						mem_req <= 1'b0;
					end
				end
				st_release:
				begin
					// ack low again, the cpu may go on
					if (!mem_ack)
					begin
						state  <= st_hold;
						wait_n <= 1'b1;
						zd_oe  <= mem_rnw;
					end
				end
				st_hold:
				begin
					if (cyc.cyc_end)
					begin
						state <= st_idle;
						zd_oe <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		if (go)
		begin
			mem_addr  <= map_addr;
			mem_rom   <= map_rom;
			mem_wdata <= cyc.wdata;
		end
		// read data valid together with ack
		if (state == st_request && mem_ack && mem_rnw)
			zd_out <= mem_rdata;
	end

	a_req_held: assert property (@(posedge fclk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req);

	a_addr_stable: assert property (@(posedge fclk) disable iff (!rst_n)
		mem_req |=> !mem_req || $stable(mem_addr));

endmodule

/* design/zx_mem_top.sv */
module zx_mem_top (
	input  logic                  fclk,
	input  logic                  rst_n,
	input  zx_bus_pkg::z_addr_t   za,
	input  zx_bus_pkg::z_data_t   zd_in,
	output zx_bus_pkg::z_data_t   zd_out,
	output logic                  zd_oe,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output logic                  wait_n,
	output logic                  mem_req,
	input  logic                  mem_ack,
	output zx_mem_pkg::mem_addr_t mem_addr,
	output logic                  mem_rnw,
	output zx_bus_pkg::z_data_t   mem_wdata,
	input  zx_bus_pkg::z_data_t   mem_rdata,
	output logic                  mem_rom
);
	import zx_mem_pkg::*;

	mem_addr_t map_addr;
	logic      map_rom;

	z80_cycle_if cyc ();

	z80_bus_sync i_z80_bus_sync (
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.cyc(cyc.src)
	);

	window_pager i_window_pager (
		.fclk(fclk), .rst_n(rst_n), .cyc(cyc.pager),
		.mem_addr(map_addr), .rom(map_rom)
	);

	mem_cycle i_mem_cycle (
		.fclk(fclk), .rst_n(rst_n), .cyc(cyc.seq),
		.map_addr(map_addr), .map_rom(map_rom),
		.mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr),
		.mem_rnw(mem_rnw), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.mem_rom(mem_rom), .wait_n(wait_n), .zd_out(zd_out), .zd_oe(zd_oe)
	);

endmodule

/* verif/tb_zx_mem.sv */
module tb_zx_mem;
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	logic      fclk;
	logic      rst_n;
	z_addr_t   za;
	z_data_t   zd_in;
	z_data_t   zd_out;
	logic      zd_oe;
	logic      mreq_n;
	logic      iorq_n;
	logic      rd_n;
	logic      wr_n;
	logic      wait_n;
	logic      mem_req;
	logic      mem_ack;
	mem_addr_t mem_addr;
	logic      mem_rnw;
	z_data_t   mem_wdata;
	z_data_t   mem_rdata;
	logic      mem_rom;

	// one entry per case line
	logic [15:0] op_q [$];
	z_addr_t     addr_q [$];
	z_data_t     data_q [$];
	mem_addr_t   exp_addr_q [$];
	logic        exp_rom_q [$];
	logic        has_rd_q [$];
	z_data_t     exp_rd_q [$];

	int          check_errs;
	int          hs_errs;
	int          cycles;
	int          limit;
	int          req_count;
	int          wait_low_cycles;
	mem_addr_t   req_addr;
	logic        req_rnw;
	z_data_t     req_wdata;
	logic        req_rom;
	z_data_t     mem_model [mem_addr_t];
	logic [31:0] rng;

	zx_mem_top i_zx_mem_top (
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in), .zd_out(zd_out),
		.zd_oe(zd_oe), .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.wait_n(wait_n), .mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr),
		.mem_rnw(mem_rnw), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.mem_rom(mem_rom)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// unwritten locations read back a pattern of the full address
	function automatic z_data_t fill_byte(input mem_addr_t a);
		return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		value_check: assert (exp == act)
		else
		begin
			check_errs++;
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		check_errs++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic read_cases();
		int          fd;
		int          n;
		string       line;
		logic [15:0] op_s;
		z_addr_t     a;
		z_data_t     d;
		mem_addr_t   ea;
		logic        er;
		z_data_t     ed;
		fd = $fopen("verif/zx_mem_cases.txt", "r");
		open_check: assert (fd != 0) else report_problem("cannot open the cases file");
		if (fd == 0)
			return;
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			// last column is none when no read data is expected
			n = $sscanf(line, "%s %h %h %h %h %h", op_s, a, d, ea, er, ed);
			line_check: assert (n == 5 || n == 6) else report_problem("unreadable case line");
			if (n != 5 && n != 6)
				continue;
			op_q.push_back(op_s);
			addr_q.push_back(a);
			data_q.push_back(d);
			exp_addr_q.push_back(ea);
			exp_rom_q.push_back(er);
			has_rd_q.push_back(n == 6);
			exp_rd_q.push_back(ed);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Z80 bus model
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_op(input logic [15:0] op, input z_addr_t a, input z_data_t d,
		output z_data_t rd, output logic oe);
		int held;
		@(negedge fclk);
		za    = a;
		zd_in = d;
		@(negedge fclk);
		case (op)
			"io":
			begin
				iorq_n = 1'b0;
				wr_n   = 1'b0;
			end
			"mw":
			begin
				mreq_n = 1'b0;
				wr_n   = 1'b0;
			end
			default:
			begin
				mreq_n = 1'b0;
				rd_n   = 1'b0;
			end
		endcase
		// strobes stay low 5 cycles, longer while wait_n holds the cpu
		held = 0;
		while (held < 5 || !wait_n)
		begin
			@(negedge fclk);
			held++;
		end
		rd = zd_out;
		oe = zd_oe;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		repeat (6) @(negedge fclk);
		compare_value("zd_oe after cycle end", 0, 32'(zd_oe));
	endtask

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// memory responder
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int delay;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		req_count = 0;
		hs_errs   = 0;
		rng       = 32'h2d15f30c;
		forever
		begin
			@(negedge fclk);
			if (mem_req && !mem_ack)
			begin
				rng   = next_random(rng);
				delay = int'(rng[2:0]);
				repeat (delay)
				begin
					@(negedge fclk);
					ack_wait: assert (!wait_n)
					else
					begin
						hs_errs++;
						$display("ERROR at %0t: wait_n high while mem_ack is held back", $time);
					end
				end
				req_count++;
				req_addr  = mem_addr;
				req_rnw   = mem_rnw;
				req_wdata = mem_wdata;
				req_rom   = mem_rom;
				if (!mem_rnw)
					mem_model[mem_addr] = mem_wdata;
				if (mem_model.exists(mem_addr))
					mem_rdata = mem_model[mem_addr];
				else
					mem_rdata = fill_byte(mem_addr);
				mem_ack = 1'b1;
				while (mem_req)
					@(negedge fclk);
				mem_ack = 1'b0;
			end
		end
	end

	always @(negedge fclk)
	begin
		if (rst_n && !wait_n)
			wait_low_cycles++;
	end

	// run limit, set once the cases are read
	initial
	begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit)
		begin
			@(posedge fclk);
			cycles++;
		end
		$display("timeout after %0d cycles, the cases did not complete", cycles);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		logic [15:0] op;
		z_data_t     rd;
		logic        oe;
		int          reqs_before;
		int          waits_before;
		check_errs      = 0;
		wait_low_cycles = 0;
		limit  = 0;
		rst_n  = 1'b0;
		za     = '0;
		zd_in  = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		read_cases();
		limit = op_q.size() * 40 + 16;
		repeat (16) @(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);
		compare_value("mem_req", 0, 32'(mem_req));
		compare_value("wait_n", 1, 32'(wait_n));
		compare_value("zd_oe", 0, 32'(zd_oe));
		foreach (op_q[i])
		begin
			op           = op_q[i];
			reqs_before  = req_count;
			waits_before = wait_low_cycles;
			bus_op(op, addr_q[i], data_q[i], rd, oe);
			if (op == "io")
			begin
				io_quiet: assert (req_count == reqs_before)
				else report_problem("I/O write made a memory request");
			end
			else if (op == "mw" && exp_rom_q[i])
			begin
				rom_quiet: assert (req_count == reqs_before)
				else report_problem("write to a ROM window made a memory request");
				rom_no_wait: assert (wait_low_cycles == waits_before)
				else report_problem("wait_n fell on a write to a ROM window");
			end
			else
			begin
				one_req: assert (req_count == reqs_before + 1)
				else report_problem("memory access did not make exactly one request");
				wait_fell: assert (wait_low_cycles > waits_before)
				else report_problem("wait_n never fell during a memory access");
				compare_value("mem_addr", 32'(exp_addr_q[i]), 32'(req_addr));
				compare_value("mem_rom", 32'(exp_rom_q[i]), 32'(req_rom));
				compare_value("mem_rnw", 32'(op == "mr"), 32'(req_rnw));
				if (op == "mw")
					compare_value("mem_wdata", 32'(data_q[i]), 32'(req_wdata));
				if (op == "mr")
					compare_value("zd_oe", 1, 32'(oe));
				if (has_rd_q[i])
					compare_value("zd_out", 32'(exp_rd_q[i]), 32'(rd));
			end
		end
		$display("%0d cases, %0d check errors, %0d handshake errors",
			op_q.size(), check_errs, hs_errs);
		if (check_errs + hs_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* verif/zx_mem_cases.txt */
# op addr data exp_mem_addr exp_rom exp_rdata, all hex
# op io = I/O write, mw = memory write, mr = memory read; exp_rdata none = not checked
mr 0123 00 000123 1 none
mr 4567 00 014567 0 none
mr 89ab 00 0089ab 0 none
mr c0de 00 0000de 0 none
mw 4100 5a 014100 0 none
mw 8200 a5 008200 0 none
mw 0010 33 000010 1 none
io 7ff7 83 000000 0 none
io 80fe 81 000000 0 none
mr 4100 00 00c100 0 none
mr 8200 00 008200 0 a5
mw c0de 77 0000de 0 none
io 3ff7 85 000000 0 none
mr 0100 00 014100 0 5a
mw 4100 3c 00c100 0 none
mr 4100 00 00c100 0 3c
io fff7 00 000000 0 none
mw c0de 99 0000de 1 none
mr c0de 00 0000de 1 77

/* zx_mem.f */
design/zx_bus_pkg.sv
design/zx_mem_pkg.sv
design/z80_cycle_if.sv
design/z80_bus_sync.sv
design/window_pager.sv
design/mem_cycle.sv
design/zx_mem_top.sv
verif/tb_zx_mem.sv

/* Makefile */
BUILD = obj_dir
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f zx_mem.f --top-module tb_zx_mem --Mdir $(BUILD)
	./$(BUILD)/Vtb_zx_mem | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f zx_mem.f --top-module tb_zx_mem

clean:
	rm -rf $(BUILD) $(LOG)
